// ==== rtl/cpb_pkg.sv ====
package cpb_pkg;

    // Buffer geometry
    localparam int buf_depth = 64;
    localparam int addr_w = $clog2(buf_depth);
    localparam int word_w = 32;

    // Write count has to reach buf_depth itself
    localparam int cnt_w = addr_w + 1;

    typedef logic [word_w-1:0] word_t;

    typedef logic [addr_w-1:0] addr_t;

    typedef logic [cnt_w-1:0] cnt_t;

    // Memory controller control, wrdone above we
    typedef struct packed {
        logic wrdone;
        logic we;
    } mc_ctrl_t;

    // One output word with its valid flag
    typedef struct packed {
        logic  valid;
        word_t data;
    } beat_t;

    localparam mc_ctrl_t mc_idle = '{
        wrdone: 1'b0,
        we:     1'b0
    };

    localparam cnt_t cnt_full = cnt_t'(buf_depth);

endpackage

// ==== rtl/single_port_ram.sv ====
`timescale 1ns/10ps

module single_port_ram #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [DATA_WIDTH-1:0] data,
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] q
);

    logic [DATA_WIDTH-1:0] mem [0:(2**ADDR_WIDTH)-1];

    // Synchronous write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
    end

    // Registered read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        q <= mem[addr];
    end

endmodule

// ==== rtl/load_ctrl.sv ====
`timescale 1ns/10ps

module load_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_valid,
    input  logic              load_last,
    input  cpb_pkg::word_t    load_data,
    output cpb_pkg::mc_ctrl_t mc,
    output cpb_pkg::word_t    wdata
);

    import cpb_pkg::*;

    cnt_t wr_cnt;
    logic room;
    logic accept;
    logic last_pend;
    logic last_dropped;

    // Space left in the buffer for this load
    assign room = (wr_cnt < cnt_full);

    assign accept = load_valid & room;

    // Final strobe arriving once the buffer is already full
    assign last_dropped = load_valid & load_last & ~room;

    // Accepted word count, back to zero on every write-done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (mc.wrdone) begin
            wr_cnt <= '0;
        end else if (accept) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // Final word is being written, write-done follows it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_pend <= 1'b0;
        end else begin
            last_pend <= accept & load_last;
        end
    end

    // Registered controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mc <= mc_idle;
        end else begin
            mc.we     <= accept;
            mc.wrdone <= last_pend | last_dropped;
        end
    end

    // Write data travels alongside we
    always_ff @(posedge clk) begin
        if (load_valid) begin
            wdata <= load_data;
        end
    end

endmodule

// ==== rtl/mem_cp.sv ====
`timescale 1ns/10ps

module mem_cp (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd,
    input  cpb_pkg::mc_ctrl_t mc,
    input  cpb_pkg::word_t    wdata,
    output logic              invalid,
    output cpb_pkg::word_t    rdata
);

    import cpb_pkg::*;

    addr_t addr_cnt;
    addr_t max_addr;
    logic  busy;
    logic  past_end;
    logic  pass_end;
    logic  at_last;

    // Counter sits on the final word of the block
    assign at_last = (addr_cnt == max_addr);

    assign invalid = mc.we | busy | pass_end;

    // One counter for both writes and reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            max_addr <= '0;
            busy     <= 1'b0;
        end else if (mc.wrdone) begin
            addr_cnt <= '0;
            busy     <= 1'b0;
        end else if (mc.we) begin
            addr_cnt <= addr_cnt + 1'b1;
            max_addr <= addr_cnt;
            busy     <= 1'b1;
        end else if (rd) begin
            // Over-read wraps back to the start of the block
            addr_cnt <= past_end ? '0 : addr_cnt + 1'b1;
        end
    end

    // past_end marks the last word read, pass_end is the sticky end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            past_end <= 1'b0;
            pass_end <= 1'b0;
        end else if (mc.wrdone) begin
            past_end <= 1'b0;
            pass_end <= 1'b0;
        end else if (rd) begin
            if (past_end) begin
                pass_end <= 1'b1;
            end else if (at_last) begin
                // Also covers a full block, where the counter rolls over on its own
                past_end <= 1'b1;
            end
        end
    end

    single_port_ram #(
        .ADDR_WIDTH (addr_w),
        .DATA_WIDTH (word_w)
    ) u_ram (
        .clk  (clk),
        .we   (mc.we),
        .data (wdata),
        .addr (addr_cnt),
        .q    (rdata)
    );

endmodule

// ==== rtl/play_out.sv ====
`timescale 1ns/10ps

module play_out (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           play,
    input  logic           invalid,
    input  cpb_pkg::word_t rdata,
    output logic           rd,
    output cpb_pkg::beat_t beat,
    output logic           pass_done
);

    import cpb_pkg::*;

    logic  pending;
    logic  keep;
    logic  overread;
    logic  beat_valid;
    word_t beat_data;

    // Read whenever allowed and the buffer holds a valid block
    assign rd = play & ~invalid;

    // Read from last cycle is a real word while the buffer stays valid
    assign keep = pending & ~invalid;

    // Invalid after a read means that read ran past the block
    assign overread = pending & invalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
            pass_done  <= 1'b0;
        end else begin
            beat_valid <= keep;
            pass_done  <= overread;
        end
    end

    // RAM data is captured only for kept reads
    always_ff @(posedge clk) begin
        if (keep) begin
            beat_data <= rdata;
        end
    end

    assign beat = '{
        valid: beat_valid,
        data:  beat_data
    };

endmodule

// ==== rtl/cp_buffer_top.sv ====
`timescale 1ns/10ps

module cp_buffer_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           load_valid,
    input  logic           load_last,
    input  cpb_pkg::word_t load_data,
    input  logic           play,
    output cpb_pkg::beat_t beat,
    output logic           pass_done,
    output logic           busy
);

    import cpb_pkg::*;

    mc_ctrl_t mc;
    word_t    wdata;
    word_t    rdata;
    logic     rd;
    logic     invalid;

    // Host strobes to write controls
    load_ctrl u_load_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .load_data  (load_data),
        .mc         (mc),
        .wdata      (wdata)
    );

    mem_cp u_mem_cp (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd      (rd),
        .mc      (mc),
        .wdata   (wdata),
        .invalid (invalid),
        .rdata   (rdata)
    );

    // Read issue and beat alignment
    play_out u_play_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .play      (play),
        .invalid   (invalid),
        .rdata     (rdata),
        .rd        (rd),
        .beat      (beat),
        .pass_done (pass_done)
    );

    assign busy = invalid;

endmodule

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Reference model, words of the current block in load order
word_t exp_q[$];

task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
endtask

task automatic report_failure(input string msg);
    $display("error in %s: %s", test_name, msg);
    stop_on_error();
endtask

task automatic check_beat(input string name, input word_t exp_word, input word_t act_word);
    if (act_word !== exp_word) begin
        $display("mismatch in %s: beat data expected 0x%08h, actual 0x%08h",
                 name, exp_word, act_word);
        stop_on_error();
    end
endtask

task automatic check_pass(input string name, input int exp_cnt, input int act_cnt);
    if (act_cnt != exp_cnt) begin
        $display("mismatch in %s: beats in pass expected %0d, actual %0d",
                 name, exp_cnt, act_cnt);
        stop_on_error();
    end
endtask

// Inputs change a little after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic wait_busy_low(input int limit);
    int cycles;
    cycles = 0;
    next_cycle();
    while (busy) begin
        if (cycles >= limit) begin
            report_failure("busy never fell after the load ended");
        end
        next_cycle();
        cycles++;
    end
endtask

// Plays until the monitor sees pass_done
task automatic run_pass(input bit toggle, input int limit);
    int start_cnt;
    int cycles;
    start_cnt = pass_cnt;
    cycles = 0;
    while (pass_cnt == start_cnt) begin
        if (cycles >= limit) begin
            report_failure("the pass never ended, no pass_done within the cycle limit");
        end
        if (toggle) begin
            play = ($urandom_range(1, 0) == 1);
        end else begin
            play = 1'b1;
        end
        next_cycle();
        cycles++;
    end
endtask

`endif

// ==== test/tb_cp_buffer.sv ====
`timescale 1ns/10ps

module tb_cp_buffer;

    import cpb_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  load_valid;
    logic  load_last;
    word_t load_data;
    logic  play;
    beat_t beat;
    logic  pass_done;
    logic  busy;

    int          pass_cnt;
    int          beats_in_pass;
    int          expected_len;
    logic        loading;
    logic        after_pass;
    string       test_name;
    word_t       exp_word;

    `include "tb_checks.svh"

    cp_buffer_top u_cp_buffer_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .load_data  (load_data),
        .play       (play),
        .beat       (beat),
        .pass_done  (pass_done),
        .busy       (busy)
    );

    always #20 clk = ~clk;

    // Scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (beat.valid) begin
                if (loading) begin
                    report_failure("a beat appeared during a load");
                end else if (after_pass) begin
                    report_failure("a beat appeared after the pass had ended");
                end else if (exp_q.size() == 0) begin
                    report_failure("a beat appeared with no word left in the block");
                end else begin
                    exp_word = exp_q.pop_front();
                    check_beat(test_name, exp_word, beat.data);
                    beats_in_pass++;
                end
            end
            if (pass_done) begin
                if (after_pass) begin
                    report_failure("pass_done pulsed twice for one pass");
                end
                check_pass(test_name, expected_len, beats_in_pass);
                after_pass = 1'b1;
                pass_cnt++;
            end
            if (after_pass && !busy) begin
                report_failure("busy dropped after the pass without a new load");
            end
        end
    end

    // Words past the buffer depth are sent but never expected back
    task automatic load_block(input int n);
        word_t w;
        int    gap;
        int    i;
        int    g;
        loading = 1'b1;
        after_pass = 1'b0;
        beats_in_pass = 0;
        expected_len = (n > buf_depth) ? buf_depth : n;
        for (i = 0; i < n; i++) begin
            w = $urandom();
            if (i < buf_depth) begin
                exp_q.push_back(w);
            end
            next_cycle();
            if (i > 0 && !busy) begin
                report_failure("busy was low in the middle of a load");
            end
            load_valid = 1'b1;
            load_data = w;
            load_last = (i == n - 1);
            // Gaps only between strobes, busy falls soon after the final one
            gap = (i == n - 1) ? 0 : $urandom_range(3, 0);
            for (g = 0; g < gap; g++) begin
                next_cycle();
                if (!busy) begin
                    report_failure("busy was low between load strobes");
                end
                load_valid = 1'b0;
                load_last = 1'b0;
            end
        end
        next_cycle();
        if (!busy) begin
            report_failure("busy was low right after the last load strobe");
        end
        load_valid = 1'b0;
        load_last = 1'b0;
        wait_busy_low(16);
        loading = 1'b0;
    endtask

    // Play stays high while the monitor checks for silence
    task automatic hold_after_pass(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            next_cycle();
            play = 1'b1;
        end
    endtask

    task automatic run_session(input string name, input int n, input bit toggle);
        test_name = name;
        load_block(n);
        run_pass(toggle, 4000);
        hold_after_pass($urandom_range(8, 3));
        if ($urandom_range(1, 0) == 0) begin
            next_cycle();
            play = 1'b0;
        end
    endtask

    initial begin
        int k;
        clk = 1'b0;
        rst_n = 1'b0;
        load_valid = 1'b0;
        load_last = 1'b0;
        load_data = '0;
        play = 1'b0;
        pass_cnt = 0;
        beats_in_pass = 0;
        expected_len = 0;
        loading = 1'b0;
        after_pass = 1'b0;
        test_name = "reset";
        void'($urandom(94509));

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        if (busy || beat.valid || pass_done) begin
            report_failure("outputs were active right after reset");
        end

        // Play must stay low until the first block is in
        run_session("continuous_play", $urandom_range(buf_depth, 1), 1'b0);
        run_session("full_depth", buf_depth, 1'b1);
        run_session("overflow_load", $urandom_range(buf_depth + 16, buf_depth + 1), 1'b1);
        run_session("single_word", 1, 1'b1);
        for (k = 0; k < 20; k++) begin
            run_session($sformatf("back_to_back_%0d", k), $urandom_range(buf_depth, 1),
                        $urandom_range(1, 0) == 1);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
rtl/cpb_pkg.sv
rtl/single_port_ram.sv
rtl/load_ctrl.sv
rtl/mem_cp.sv
rtl/play_out.sv
rtl/cp_buffer_top.sv
test/tb_cp_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cp_buffer
RTL_TOP   ?= cp_buffer_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only rtl/cpb_pkg.sv rtl/single_port_ram.sv rtl/load_ctrl.sv \
		rtl/mem_cp.sv rtl/play_out.sv rtl/cp_buffer_top.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
